// File: hdl/hl_pkg.sv
/*
  shared types and constants for the host-to-radio downlink path
  host words arrive already byte-swapped to big endian (sync byte in [15:8])
  frame layout assumes 512-byte frames with an 8-byte sync and C&C header
*/

package hl_pkg;

  // ----------------------------------------------------------------------
  // plain vector widths
  // ----------------------------------------------------------------------
  typedef logic [15:0] sample_t;
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;
  // bit 1 marks second word of a pair, bit 0 is the id bit
  typedef logic [1:0]  iq_tag_t;
  typedef logic [17:0] cw_level_t;

  // ----------------------------------------------------------------------
  // bundles
  // ----------------------------------------------------------------------
  typedef struct packed {
    iq_tag_t tag;
    sample_t sample;
  } iq_word_t;

  // command response back to host
  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
  } cmd_resp_t;

  // wishbone classic request, master to slave
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    cmd_addr_t adr;
    cmd_data_t dat;
  } wb_req_t;

  // ----------------------------------------------------------------------
  // state machines
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    st_idle, st_start, st_rx_1_2, st_rx_3_4,
    st_pay_1, st_pay_2, st_pay_3, st_pay_4
  } sync_state_t;

  typedef enum logic [1:0] {cw_rx, cw_keydown, cw_keyup} cw_state_t;

  // frame constants
  localparam sample_t    SYNC_WORD           = 16'h7F7F;
  localparam logic [7:0] SYNC_BYTE           = 8'h7F;
  localparam int         FRAME_PAYLOAD_WORDS = (512 - 8) / 2;

  // decoded command addresses
  localparam cmd_addr_t ADDR_RX_CTRL1 = 6'h00;
  localparam cmd_addr_t ADDR_PA_CTRL  = 6'h09;

endpackage

// File: hdl/frame_sync_decoder.sv
/*
  sync search and C&C decode for host frames, one word per accepted cycle
  word_ready_o is registered, so it lags the FIFO count by one cycle
  FIFO_DEPTH must exceed FRAME_PAYLOAD_WORDS plus a few words of slack
*/
`timescale 1ns/100ps

module frame_sync_decoder
  import hl_pkg::*;
#(
  parameter int FIFO_DEPTH = 512
) (
  input  logic                           clk_ad9866,
  input  logic                           rst,
  input  sample_t                        word_i,
  input  logic                           word_valid_i,
  output logic                           word_ready_o,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_i,
  output logic                           iq_push_o,
  output iq_word_t                       iq_word_o,
  output wb_req_t                        wb_req_o,
  input  logic                           wb_ack_i,
  output logic                           mox_o,
  output cmd_resp_t                      resp_o,
  output logic                           resp_valid_o,
  input  logic                           resp_ready_i
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  // a whole frame of payload must still fit
  localparam logic [CNT_W-1:0] ROOM_LIMIT = CNT_W'(FIFO_DEPTH - FRAME_PAYLOAD_WORDS);
  localparam logic [7:0] LAST_WORD = 8'(FRAME_PAYLOAD_WORDS - 1);

  sync_state_t state;
  sync_state_t next_pay;
  logic [7:0]  pay_cnt;
  logic        ready_q;
  logic        accept;
  logic        resp_rqst_q;
  logic        mox_q;
  cmd_addr_t   addr_q;
  cmd_data_t   data_q;
  logic        wb_cyc_q;
  logic        resp_load;
  logic        resp_valid_q;
  cmd_resp_t   resp_q;

  assign accept = word_valid_i & ready_q;

  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= (fifo_count_i < ROOM_LIMIT);
    end
  end

  // ----------------------------------------------------------------------
  // frame FSM
  // ----------------------------------------------------------------------
  // four-phase payload rotation
  always_comb begin
    case (state)
      st_pay_1: next_pay = st_pay_2;
      st_pay_2: next_pay = st_pay_3;
      st_pay_3: next_pay = st_pay_4;
      default:  next_pay = st_pay_1;
    endcase
  end

  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      state       <= st_idle;
      pay_cnt     <= '0;
      resp_rqst_q <= 1'b0;
      mox_q       <= 1'b0;
    end else if (accept) begin
      case (state)
        st_idle: begin
          if (word_i == SYNC_WORD) state <= st_start;
        end
        // third sync byte plus control byte 0
        st_start: begin
          if (word_i[15:8] == SYNC_BYTE) begin
            resp_rqst_q <= word_i[7];
            mox_q       <= word_i[0];
            state       <= st_rx_1_2;
          end else begin
            state <= st_idle;
          end
        end
        st_rx_1_2: state <= st_rx_3_4;
        st_rx_3_4: begin
          pay_cnt <= '0;
          state   <= st_pay_1;
        end
        default: begin
          if (pay_cnt == LAST_WORD) begin
            state <= st_idle;
          end else begin
            pay_cnt <= pay_cnt + 8'd1;
            state   <= next_pay;
          end
        end
      endcase
    end
  end

  // header fields
  always_ff @(posedge clk_ad9866) begin
    if (accept) begin
      if (state == st_start && word_i[15:8] == SYNC_BYTE) addr_q <= word_i[6:1];
      if (state == st_rx_1_2) data_q[31:16] <= word_i;
      if (state == st_rx_3_4) data_q[15:0] <= word_i;
    end
  end

  // payload routing, pay_1 and pay_2 words are the unused LR stream
  assign iq_push_o        = accept & (state == st_pay_3 || state == st_pay_4);
  assign iq_word_o.sample = word_i;
  assign iq_word_o.tag    = (state == st_pay_4) ? {1'b1, addr_q[2]} : addr_q[1:0];

  // ----------------------------------------------------------------------
  // wishbone single write and response
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      wb_cyc_q <= 1'b0;
    end else if (accept && state == st_rx_3_4) begin
      wb_cyc_q <= 1'b1;
    end else if (wb_ack_i) begin
      wb_cyc_q <= 1'b0;
    end
  end

  assign wb_req_o.cyc = wb_cyc_q;
  assign wb_req_o.stb = wb_cyc_q;
  assign wb_req_o.we  = wb_cyc_q;
  assign wb_req_o.adr = addr_q;
  assign wb_req_o.dat = data_q;

  // one-entry response slot, new response dropped while one waits
  assign resp_load = wb_cyc_q & wb_ack_i & resp_rqst_q & (~resp_valid_q | resp_ready_i);

  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      resp_valid_q <= 1'b0;
    end else if (resp_load) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_ad9866) begin
    if (resp_load) begin
      resp_q.addr <= addr_q;
      resp_q.data <= data_q;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;
  assign word_ready_o = ready_q;
  assign mox_o        = mox_q;

endmodule

// File: hdl/tx_iq_fifo.sv
/*
  single-clock first-word-fall-through FIFO for tagged transmit IQ words
  FIFO_DEPTH must be a power of two, pointers wrap naturally
  the writer must never push when full, there is no overflow guard
*/
`timescale 1ns/100ps

module tx_iq_fifo
  import hl_pkg::*;
#(
  parameter int FIFO_DEPTH = 512
) (
  input  logic                            clk_ad9866,
  input  logic                            rst,
  input  logic                            push_i,
  input  iq_word_t                        data_i,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] count_o,
  output iq_word_t                        iq_o,
  output logic                            iq_valid_o,
  input  logic                            iq_ready_i
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  iq_word_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  // head word visible as soon as count is nonzero
  assign iq_valid_o = (count_q != '0);
  assign pop        = iq_valid_o & iq_ready_i;
  assign iq_o       = mem[rd_ptr];
  assign count_o    = count_q;

  always_ff @(posedge clk_ad9866) begin
    if (push_i) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) wr_ptr <= wr_ptr + PTR_W'(1);
      if (pop) rd_ptr <= rd_ptr + PTR_W'(1);
      // simultaneous push and pop leaves the count alone
      case ({push_i, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: hdl/key_conditioner.sv
/*
  debounce for CW key, PTT and TX inhibit, all active low at the pins
  latency is DEBOUNCE_CYCLES plus two synchronizer cycles
  CW envelope steps by one per clock between zero and MAX_CWLEVEL
*/
`timescale 1ns/100ps

module key_conditioner
  import hl_pkg::*;
#(
  parameter int        DEBOUNCE_CYCLES = 250000,
  parameter cw_level_t MAX_CWLEVEL     = 18'h26C00
) (
  input  logic      clk_ad9866,
  input  logic      rst,
  input  logic      cwkey_n_i,
  input  logic      ptt_n_i,
  input  logic      txinhibit_n_i,
  output logic      cw_active_o,
  output cw_level_t cw_level_o,
  output logic      ptt_clean_o,
  output logic      inhibit_o
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

  // bit 0 cw key, bit 1 ptt, bit 2 inhibit
  logic [2:0]       key_raw;
  logic [2:0]       sync_1;
  logic [2:0]       sync_2;
  logic [2:0]       clean;
  logic [CNT_W-1:0] db_cnt [3];
  cw_state_t        cw_state;
  cw_level_t        cw_level;

  assign key_raw = ~{txinhibit_n_i, ptt_n_i, cwkey_n_i};

  // ----------------------------------------------------------------------
  // synchronizer and per-input debounce counters
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      sync_1 <= '0;
      sync_2 <= '0;
      clean  <= '0;
      for (int i = 0; i < 3; i++) db_cnt[i] <= '0;
    end else begin
      sync_1 <= key_raw;
      sync_2 <= sync_1;
      for (int i = 0; i < 3; i++) begin
        // restart whenever input agrees with the clean level again
        if (sync_2[i] == clean[i]) begin
          db_cnt[i] <= '0;
        end else if (db_cnt[i] == CNT_LAST) begin
          db_cnt[i] <= '0;
          clean[i]  <= sync_2[i];
        end else begin
          db_cnt[i] <= db_cnt[i] + CNT_W'(1);
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // CW envelope ramp
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      cw_state <= cw_rx;
      cw_level <= '0;
    end else begin
      case (cw_state)
        cw_rx: begin
          cw_level <= '0;
          if (clean[0]) cw_state <= cw_keydown;
        end
        cw_keydown: begin
          if (cw_level != MAX_CWLEVEL) cw_level <= cw_level + 18'd1;
          if (!clean[0]) cw_state <= cw_keyup;
        end
        // ramp fully down before listening to the key again
        default: begin
          if (cw_level == '0) begin
            cw_state <= cw_rx;
          end else begin
            cw_level <= cw_level - 18'd1;
          end
        end
      endcase
    end
  end

  assign cw_active_o = (cw_state != cw_rx);
  assign cw_level_o  = cw_level;
  assign ptt_clean_o = clean[1];
  assign inhibit_o   = clean[2];

endmodule

// File: hdl/tr_control.sv
/*
  wishbone classic slave holding the RX and PA control fields
  ack follows stb by one cycle, data is written at the end of the ack cycle
  writes to unknown addresses are acked and ignored
*/
`timescale 1ns/100ps

module tr_control
  import hl_pkg::*;
(
  input  logic       clk_ad9866,
  input  logic       rst,
  input  wb_req_t    wb_req_i,
  output logic       wb_ack_o,
  input  logic       mox_i,
  input  logic       cw_active_i,
  input  logic       ptt_clean_i,
  input  logic       inhibit_i,
  output logic [4:0] last_chan_o,
  output logic       vna_o,
  output logic       ptt_o,
  output logic       pa_tr_o,
  output logic       pa_en_o,
  output logic       rfsw_sel_o
);

  logic       ack_q;
  logic       wr_hit;
  logic [4:0] last_chan;
  logic       vna;
  logic       pa_enable;
  logic       tr_disable;
  logic       ptt;

  // ----------------------------------------------------------------------
  // bus handshake
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      // single-cycle ack pulse
      ack_q <= wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    end
  end

  assign wr_hit   = wb_req_i.cyc & wb_req_i.stb & wb_req_i.we & ack_q;
  assign wb_ack_o = ack_q;

  // ----------------------------------------------------------------------
  // control fields
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_ad9866) begin
    if (rst) begin
      last_chan  <= '0;
      vna        <= 1'b0;
      pa_enable  <= 1'b0;
      tr_disable <= 1'b0;
    end else if (wr_hit) begin
      case (wb_req_i.adr)
        // number of receive streams minus one
        ADDR_RX_CTRL1: last_chan <= wb_req_i.dat[7:3];
        ADDR_PA_CTRL: begin
          vna        <= wb_req_i.dat[23];
          pa_enable  <= wb_req_i.dat[19];
          tr_disable <= wb_req_i.dat[18];
        end
        default: ;
      endcase
    end
  end

  // transmit request from any source, inhibit wins
  assign ptt = (mox_i | cw_active_i | ptt_clean_i) & ~inhibit_i;

  assign ptt_o       = ptt;
  // tr relay also follows ptt when no PA but tr switching enabled
  assign pa_tr_o     = ptt & (pa_enable | ~tr_disable);
  assign pa_en_o     = ptt & pa_enable;
  assign rfsw_sel_o  = pa_enable;
  assign last_chan_o = last_chan;
  assign vna_o       = vna;

endmodule

// File: hdl/hl_downlink_top.sv
/*
  host-to-radio downlink top, single clock domain clk_ad9866
  input words must already be big endian, sync byte in the upper half
*/
`timescale 1ns/100ps

module hl_downlink_top
  import hl_pkg::*;
#(
  parameter int        FIFO_DEPTH      = 512,
  parameter int        DEBOUNCE_CYCLES = 250000,
  parameter cw_level_t MAX_CWLEVEL     = 18'h26C00
) (
  input  logic       clk_ad9866,
  input  logic       rst,
  input  sample_t    word_i,
  input  logic       word_valid_i,
  output logic       word_ready_o,
  output iq_word_t   iq_o,
  output logic       iq_valid_o,
  input  logic       iq_ready_i,
  output cmd_resp_t  resp_o,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  input  logic       cwkey_n_i,
  input  logic       ptt_n_i,
  input  logic       txinhibit_n_i,
  output cw_level_t  cw_level_o,
  output logic       cw_active_o,
  output logic [4:0] last_chan_o,
  output logic       vna_o,
  output logic       ptt_o,
  output logic       pa_tr_o,
  output logic       pa_en_o,
  output logic       rfsw_sel_o
);

  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count;
  logic     iq_push;
  iq_word_t iq_word;
  wb_req_t  wb_req;
  logic     wb_ack;
  logic     mox;
  logic     ptt_clean;
  logic     inhibit;

  // ----------------------------------------------------------------------
  // frame path
  // ----------------------------------------------------------------------
  frame_sync_decoder #(.FIFO_DEPTH(FIFO_DEPTH)) u_decoder (
    .clk_ad9866, .rst, .word_i, .word_valid_i, .word_ready_o,
    .fifo_count_i(fifo_count), .iq_push_o(iq_push), .iq_word_o(iq_word),
    .wb_req_o(wb_req), .wb_ack_i(wb_ack), .mox_o(mox),
    .resp_o, .resp_valid_o, .resp_ready_i
  );

  tx_iq_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_iq_fifo (
    .clk_ad9866, .rst, .push_i(iq_push), .data_i(iq_word),
    .count_o(fifo_count), .iq_o, .iq_valid_o, .iq_ready_i
  );

  // ----------------------------------------------------------------------
  // key inputs and TR switching
  // ----------------------------------------------------------------------
  key_conditioner #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
    .MAX_CWLEVEL(MAX_CWLEVEL)
  ) u_keys (
    .clk_ad9866, .rst, .cwkey_n_i, .ptt_n_i, .txinhibit_n_i,
    .cw_active_o, .cw_level_o, .ptt_clean_o(ptt_clean), .inhibit_o(inhibit)
  );

  tr_control u_tr (
    .clk_ad9866, .rst, .wb_req_i(wb_req), .wb_ack_o(wb_ack),
    .mox_i(mox), .cw_active_i(cw_active_o), .ptt_clean_i(ptt_clean),
    .inhibit_i(inhibit), .last_chan_o, .vna_o, .ptt_o, .pa_tr_o,
    .pa_en_o, .rfsw_sel_o
  );

endmodule

// File: test/tb_clock.sv
/*
  testbench clock and reset, 8 ns period
  reset is released on a falling edge after RESET_CYCLES rising edges
*/
`timescale 1ns/100ps

module tb_clock #(
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: test/tb_checker.sv
/*
  reference model and scoreboard for the downlink DUT
  frames are announced by the testbench top before they are driven
  samples DUT outputs on the rising edge, inputs change on the falling edge
*/
`timescale 1ns/100ps

module tb_checker
  import hl_pkg::*;
#(
  parameter cw_level_t MAX_LEVEL = 64
) (
  input logic       clk_ad9866,
  input logic       rst,
  input iq_word_t   iq_i,
  input logic       iq_valid_i,
  input logic       iq_ready_i,
  input cmd_resp_t  resp_i,
  input logic       resp_valid_i,
  input logic       resp_ready_i,
  input cw_level_t  cw_level_i,
  input logic       cw_active_i,
  input logic [4:0] last_chan_i,
  input logic       vna_i,
  input logic       ptt_i,
  input logic       pa_tr_i,
  input logic       pa_en_i,
  input logic       rfsw_sel_i
);

  iq_word_t   iq_exp[$];
  cmd_resp_t  resp_exp[$];
  int         iq_errors = 0;
  int         resp_errors = 0;
  int         out_errors = 0;
  // register model
  logic [4:0] last_chan_m = '0;
  logic       vna_m = 1'b0;
  logic       pa_enable_m = 1'b0;
  logic       tr_disable_m = 1'b0;
  logic       mox_m = 1'b0;
  cw_level_t  prev_level = '0;

  // ----------------------------------------------------------------------
  // frame announcement, builds the expected streams
  // ----------------------------------------------------------------------
  task automatic add_frame(input logic corrupt, input logic resp, input cmd_addr_t addr,
                           input logic mox, input cmd_data_t data, input sample_t start);
    iq_word_t w;
    // bad sync byte, the frame leaves no trace
    if (!corrupt) begin
      mox_m = mox;
      if (addr == 6'h00) last_chan_m = data[7:3];
      if (addr == 6'h09) begin
        vna_m        = data[23];
        pa_enable_m  = data[19];
        tr_disable_m = data[18];
      end
      if (resp) resp_exp.push_back({addr, data});
      // only payload phases 2 and 3 of each group of four carry IQ
      for (int k = 0; k < 252; k++) begin
        w.sample = start + sample_t'(k);
        if (k % 4 == 2) begin
          w.tag = addr[1:0];
          iq_exp.push_back(w);
        end else if (k % 4 == 3) begin
          w.tag = {1'b1, addr[2]};
          iq_exp.push_back(w);
        end
      end
    end
  endtask

  // static outputs, called while the DUT is quiet
  task automatic check_outputs(input logic ptt_key, input logic inhibit_key,
                               input logic cw_on);
    logic ptt_e;
    ptt_e = (mox_m | cw_on | ptt_key) & ~inhibit_key;
    if (last_chan_i !== last_chan_m || vna_i !== vna_m || rfsw_sel_i !== pa_enable_m) begin
      $display("Fail at %0t: regs last_chan %0d vna %b rfsw %b, expected %0d %b %b",
               $time, last_chan_i, vna_i, rfsw_sel_i, last_chan_m, vna_m, pa_enable_m);
      out_errors++;
    end
    if (ptt_i !== ptt_e || pa_tr_i !== (ptt_e & (pa_enable_m | ~tr_disable_m))
        || pa_en_i !== (ptt_e & pa_enable_m)) begin
      $display("Fail at %0t: ptt %b pa_tr %b pa_en %b, expected ptt %b", $time,
               ptt_i, pa_tr_i, pa_en_i, ptt_e);
      out_errors++;
    end
    if (cw_active_i !== cw_on || (!cw_on && cw_level_i != '0)) begin
      $display("Fail at %0t: cw_active %b level %0d, expected active %b", $time,
               cw_active_i, cw_level_i, cw_on);
      out_errors++;
    end
  endtask

  // ----------------------------------------------------------------------
  // streaming compares
  // ----------------------------------------------------------------------
  always @(posedge clk_ad9866) begin
    if (!rst) begin
      if (iq_valid_i && iq_ready_i) begin
        if (iq_exp.size() == 0) begin
          $display("IQ word %h came out although none was expected", iq_i);
          iq_errors++;
        end else if (iq_i !== iq_exp[0]) begin
          $display("Fail at %0t: iq word %h expected %h", $time, iq_i, iq_exp[0]);
          iq_errors++;
          void'(iq_exp.pop_front());
        end else begin
          void'(iq_exp.pop_front());
        end
      end
      if (resp_valid_i && resp_ready_i) begin
        if (resp_exp.size() == 0) begin
          $display("response %h came out although none was expected", resp_i);
          resp_errors++;
        end else begin
          if (resp_i !== resp_exp[0]) begin
            $display("Fail at %0t: response %h expected %h", $time, resp_i, resp_exp[0]);
            resp_errors++;
          end
          void'(resp_exp.pop_front());
        end
      end
      // envelope moves at most one step per clock and stays in range
      if (cw_level_i > MAX_LEVEL || (cw_level_i > prev_level + 18'd1)
          || (prev_level > cw_level_i + 18'd1)) begin
        $display("Fail at %0t: cw level jumped from %0d to %0d", $time, prev_level, cw_level_i);
        out_errors++;
      end
      prev_level <= cw_level_i;
    end
  end

  function automatic int pending();
    return iq_exp.size() + resp_exp.size();
  endfunction

  task automatic report_leftovers();
    if (pending() != 0) begin
      $display("%0d IQ words and %0d responses never arrived", iq_exp.size(), resp_exp.size());
      iq_errors += iq_exp.size();
      resp_errors += resp_exp.size();
    end
  endtask

  function automatic int total_errors();
    return iq_errors + resp_errors + out_errors;
  endfunction

endmodule

// File: test/hl_downlink_assert.sv
/*
  protocol assertions on the internal command bus and the IQ FIFO
  bound into every hl_downlink_top instance
*/
`timescale 1ns/100ps

module hl_downlink_assert
  import hl_pkg::*;
#(
  parameter int FIFO_DEPTH = 512
) (
  input logic                            clk_ad9866,
  input logic                            rst,
  input wb_req_t                         wb_req_i,
  input logic                            wb_ack_i,
  input logic                            iq_push_i,
  input logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_i,
  input iq_word_t                        iq_i,
  input logic                            iq_valid_i,
  input logic                            iq_ready_i
);

  // ack only inside a bus cycle
  ack_in_cycle: assert property (@(posedge clk_ad9866) disable iff (rst)
    wb_ack_i |-> wb_req_i.cyc && wb_req_i.stb)
    else $error("wishbone ack without cyc and stb");

  // slave answers one cycle after stb
  ack_latency: assert property (@(posedge clk_ad9866) disable iff (rst)
    $rose(wb_req_i.stb) |=> wb_ack_i)
    else $error("wishbone ack late");

  // master holds the request until ack
  req_held: assert property (@(posedge clk_ad9866) disable iff (rst)
    wb_req_i.stb && !wb_ack_i |=> wb_req_i.stb && $stable(wb_req_i.adr)
      && $stable(wb_req_i.dat))
    else $error("wishbone request dropped before ack");

  no_overflow: assert property (@(posedge clk_ad9866) disable iff (rst)
    iq_push_i |-> fifo_count_i < FIFO_DEPTH)
    else $error("push into a full IQ FIFO");

  // head word stays put while stalled
  iq_hold: assert property (@(posedge clk_ad9866) disable iff (rst)
    iq_valid_i && !iq_ready_i |=> iq_valid_i && $stable(iq_i))
    else $error("IQ output changed under back-pressure");

endmodule

bind hl_downlink_top hl_downlink_assert #(.FIFO_DEPTH(FIFO_DEPTH)) u_assert (
  .clk_ad9866(clk_ad9866), .rst(rst), .wb_req_i(wb_req), .wb_ack_i(wb_ack),
  .iq_push_i(iq_push), .fifo_count_i(fifo_count), .iq_i(iq_o),
  .iq_valid_i(iq_valid_o), .iq_ready_i(iq_ready_i)
);

// File: test/tb_top.sv
/*
  testbench top, frames come from test/testdata_frames.txt
  run from the project root so the data path resolves
  first data word is the frame count, then six fields per frame
*/
`timescale 1ns/100ps

module tb_top;
  import hl_pkg::*;

  localparam int        FIFO_DEPTH = 512;
  localparam int        DEBOUNCE   = 16;
  localparam cw_level_t MAX_LEVEL  = 64;
  localparam int        TD_WORDS   = 1 + 6 * 16;

  logic        clk_ad9866;
  logic        rst;
  sample_t     word;
  logic        word_valid;
  logic        word_ready;
  iq_word_t    iq;
  logic        iq_valid;
  logic        iq_ready = 1'b0;
  cmd_resp_t   resp;
  logic        resp_valid;
  logic        resp_ready;
  logic        cwkey_n;
  logic        ptt_n;
  logic        txinhibit_n;
  cw_level_t   cw_level;
  logic        cw_active;
  logic [4:0]  last_chan;
  logic        vna;
  logic        ptt;
  logic        pa_tr;
  logic        pa_en;
  logic        rfsw_sel;
  logic [31:0] td [TD_WORDS];
  integer      seed = 93;
  int          frames;
  int          cycles = 0;
  int          limit = 0;
  logic        seen_ready = 1'b0;
  logic        fill_done = 1'b0;

  tb_clock u_clock (.clk_o(clk_ad9866), .rst_o(rst));

  hl_downlink_top #(
    .FIFO_DEPTH(FIFO_DEPTH), .DEBOUNCE_CYCLES(DEBOUNCE), .MAX_CWLEVEL(MAX_LEVEL)
  ) dut (
    .clk_ad9866, .rst, .word_i(word), .word_valid_i(word_valid),
    .word_ready_o(word_ready), .iq_o(iq), .iq_valid_o(iq_valid), .iq_ready_i(iq_ready),
    .resp_o(resp), .resp_valid_o(resp_valid), .resp_ready_i(resp_ready),
    .cwkey_n_i(cwkey_n), .ptt_n_i(ptt_n), .txinhibit_n_i(txinhibit_n),
    .cw_level_o(cw_level), .cw_active_o(cw_active), .last_chan_o(last_chan),
    .vna_o(vna), .ptt_o(ptt), .pa_tr_o(pa_tr), .pa_en_o(pa_en), .rfsw_sel_o(rfsw_sel)
  );

  tb_checker #(.MAX_LEVEL(MAX_LEVEL)) chk (
    .clk_ad9866, .rst, .iq_i(iq), .iq_valid_i(iq_valid), .iq_ready_i(iq_ready),
    .resp_i(resp), .resp_valid_i(resp_valid), .resp_ready_i(resp_ready),
    .cw_level_i(cw_level), .cw_active_i(cw_active), .last_chan_i(last_chan),
    .vna_i(vna), .ptt_i(ptt), .pa_tr_i(pa_tr), .pa_en_i(pa_en), .rfsw_sel_i(rfsw_sel)
  );

  // IQ output held off until the full FIFO stops the input,
  // then random back-pressure, ready about three cycles in four
  always @(negedge clk_ad9866) begin
    if (word_ready) seen_ready <= 1'b1;
    if (seen_ready && !word_ready) fill_done <= 1'b1;
    iq_ready <= fill_done && (($random(seed) & 3) != 0);
  end

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_ad9866);
  endtask

  // ready is registered, its falling-edge value holds at the next rising edge
  task automatic send_word(input sample_t w);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_ad9866);
      if (($random(seed) & 7) == 0) begin
        word_valid = 1'b0;
      end else begin
        word_valid = 1'b1;
        word       = w;
        taken      = word_ready;
      end
    end
  endtask

  task automatic run_frame(input int f);
    int        base;
    logic      corrupt;
    logic      resp_bit;
    cmd_addr_t addr;
    logic      mox;
    cmd_data_t data;
    sample_t   start;
    logic [7:0] sync_b;
    base     = 1 + 6 * f;
    corrupt  = td[base][0];
    resp_bit = td[base + 1][0];
    addr     = td[base + 2][5:0];
    mox      = td[base + 3][0];
    data     = td[base + 4];
    start    = td[base + 5][15:0];
    sync_b   = corrupt ? 8'h7E : SYNC_BYTE;
    chk.add_frame(corrupt, resp_bit, addr, mox, data, start);
    send_word(SYNC_WORD);
    send_word({sync_b, resp_bit, addr, mox});
    send_word(data[31:16]);
    send_word(data[15:0]);
    for (int k = 0; k < FRAME_PAYLOAD_WORDS; k++) begin
      send_word(start + sample_t'(k));
    end
    @(negedge clk_ad9866);
    word_valid = 1'b0;
    wait_cycles(4);
    chk.check_outputs(1'b0, 1'b0, 1'b0);
  endtask

  task automatic finish_run();
    $display("errors: iq %0d, response %0d, outputs %0d, total %0d",
             chk.iq_errors, chk.resp_errors, chk.out_errors, chk.total_errors());
    if (chk.total_errors() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // ----------------------------------------------------------------------
  // timeout
  // ----------------------------------------------------------------------
  always @(posedge clk_ad9866) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("run stopped after %0d cycles, the DUT did not finish in time", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    word        = '0;
    word_valid  = 1'b0;
    resp_ready  = 1'b1;
    cwkey_n     = 1'b1;
    ptt_n       = 1'b1;
    txinhibit_n = 1'b1;
    $readmemh("test/testdata_frames.txt", td);
    frames = int'(td[0]);
    limit  = frames * 300 + 2000;
    @(negedge clk_ad9866);
    while (rst) @(negedge clk_ad9866);
    // everything low out of reset
    chk.check_outputs(1'b0, 1'b0, 1'b0);
    // external PTT before any PA command, PA enable still low
    ptt_n = 1'b0;
    wait_cycles(3 * DEBOUNCE);
    chk.check_outputs(1'b1, 1'b0, 1'b0);
    ptt_n = 1'b1;
    wait_cycles(3 * DEBOUNCE);
    chk.check_outputs(1'b0, 1'b0, 1'b0);
    for (int f = 0; f < frames; f++) run_frame(f);
    while (chk.pending() != 0) @(negedge clk_ad9866);
    // external PTT, then inhibit on top of it
    ptt_n = 1'b0;
    wait_cycles(3 * DEBOUNCE);
    chk.check_outputs(1'b1, 1'b0, 1'b0);
    txinhibit_n = 1'b0;
    wait_cycles(3 * DEBOUNCE);
    chk.check_outputs(1'b1, 1'b1, 1'b0);
    ptt_n       = 1'b1;
    txinhibit_n = 1'b1;
    wait_cycles(3 * DEBOUNCE);
    chk.check_outputs(1'b0, 1'b0, 1'b0);
    // CW key held until full envelope, then released
    cwkey_n = 1'b0;
    while (cw_level != MAX_LEVEL) @(negedge clk_ad9866);
    chk.check_outputs(1'b0, 1'b0, 1'b1);
    cwkey_n = 1'b1;
    while (cw_active) @(negedge clk_ad9866);
    wait_cycles(2);
    chk.check_outputs(1'b0, 1'b0, 1'b0);
    chk.report_leftovers();
    finish_run();
  end

endmodule

// File: compile.f
hdl/hl_pkg.sv
hdl/frame_sync_decoder.sv
hdl/tx_iq_fifo.sv
hdl/key_conditioner.sv
hdl/tr_control.sv
hdl/hl_downlink_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/hl_downlink_assert.sv
test/tb_top.sv

// File: Makefile
# Verilator build and run for the downlink testbench
TOP := tb_top
SRCS := $(wildcard hdl/*.sv test/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SRCS) compile.f
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: test/testdata_frames.txt
// first word: frame count
// then one frame per line: corrupt resp addr mox data payload_start
6
0 1 00 0 000000A8 0100
0 0 09 0 00880000 1000
1 1 00 1 FFFFFFF8 2000
0 1 05 1 FFFFFFFF 3000
0 0 00 1 00040018 4000
0 1 09 0 00080000 5000
